// ==== logic/core_settings.svh ====
// core-wide macros: reset pc, data width, register count
`ifndef CORE_SETTINGS_SVH
`define CORE_SETTINGS_SVH

// first fetch address after reset, start of the text segment
`define CORE_TEXT_START 32'h0040_0000

// data and byte address width
`define CORE_XLEN 32

// architectural register count, r0 included
`define CORE_NREGS 32

`endif

// ==== logic/mips_isa_pkg.sv ====
// mips instruction encoding: opcodes, funct codes, regimm rt codes, instruction union
package mips_isa_pkg;

   // primary opcodes kept by the core
   typedef enum logic [5:0] {
      OP_SPECIAL = 6'h00,
      OP_REGIMM  = 6'h01,
      OP_J       = 6'h02,
      OP_JAL     = 6'h03,
      OP_BEQ     = 6'h04,
      OP_BNE     = 6'h05,
      OP_BLEZ    = 6'h06,
      OP_BGTZ    = 6'h07,
      OP_ADDI    = 6'h08,
      OP_ADDIU   = 6'h09,
      OP_SLTI    = 6'h0a,
      OP_ANDI    = 6'h0c,
      OP_ORI     = 6'h0d,
      OP_XORI    = 6'h0e,
      OP_LUI     = 6'h0f,
      OP_LW      = 6'h23,
      OP_SW      = 6'h2b
   } opcode_e;

   // funct field under OP_SPECIAL
   typedef enum logic [5:0] {
      FN_SLL     = 6'h00,
      FN_SRL     = 6'h02,
      FN_SRA     = 6'h03,
      FN_JR      = 6'h08,
      FN_SYSCALL = 6'h0c,
      FN_ADD     = 6'h20,
      FN_ADDU    = 6'h21,
      FN_SUB     = 6'h22,
      FN_SUBU    = 6'h23,
      FN_AND     = 6'h24,
      FN_OR      = 6'h25,
      FN_XOR     = 6'h26,
      FN_NOR     = 6'h27,
      FN_SLT     = 6'h2a
   } funct_e;

   // rt field under OP_REGIMM picks the branch
   typedef enum logic [4:0] {
      RI_BLTZ = 5'h00,
      RI_BGEZ = 5'h01
   } regimm_e;

   typedef struct packed {
      opcode_e     op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [4:0]  rd;
      logic [4:0]  shamt;
      funct_e      funct;
   } r_fmt_t;

   typedef struct packed {
      opcode_e     op;
      logic [4:0]  rs;
      logic [4:0]  rt;
      logic [15:0] imm16;
   } i_fmt_t;

   typedef struct packed {
      opcode_e     op;
      logic [25:0] target26;
   } j_fmt_t;

   // one fetched word, seen as r, i or j format
   typedef union packed {
      r_fmt_t r;
      i_fmt_t i;
      j_fmt_t j;
   } mips_instr_u;

endpackage

// ==== logic/core_ctrl_pkg.sv ====
// core control types: alu op, branch compare, next-pc select, control word, data request
`include "core_settings.svh"

package core_ctrl_pkg;

   typedef enum logic [3:0] {
      ALU_ADD,
      ALU_SUB,
      ALU_AND,
      ALU_OR,
      ALU_XOR,
      ALU_NOR,
      ALU_SLT,
      ALU_SLL,
      ALU_SRL,
      ALU_SRA,
      // lui passes the pre-shifted immediate through
      ALU_PASS_B
   } alu_op_e;

   // rs is compared against rt for eq/ne, against zero otherwise
   typedef enum logic [2:0] {
      BR_NONE,
      BR_EQ,
      BR_NE,
      BR_LTZ,
      BR_GEZ,
      BR_LEZ,
      BR_GTZ
   } br_cond_e;

   typedef enum logic [1:0] {
      PC_SEQ,
      PC_BRANCH,
      PC_JUMP,
      PC_REG
   } pc_sel_e;

   typedef struct packed {
      logic     reg_we;
      logic     dst_rd;
      logic     link;
      logic     use_imm;
      logic     mem_to_reg;
      logic     mem_we;
      alu_op_e  alu_op;
      br_cond_e br_cond;
      pc_sel_e  pc_sel;
      logic     halt_req;
   } ctrl_word_t;

   // word addressed, single write enable, no byte lanes
   typedef struct packed {
      logic [`CORE_XLEN-3:0] addr;
      logic [`CORE_XLEN-1:0] wdata;
      logic                  we;
   } dmem_req_t;

endpackage

// ==== logic/instr_decoder.sv ====
// instruction decoder: control word and extended immediate from one instruction word
`timescale 1ns/1ps

module instr_decoder (
   input  mips_isa_pkg::mips_instr_u instr,
   output core_ctrl_pkg::ctrl_word_t ctrl,
   output logic [31:0]               imm_ext
);
   import mips_isa_pkg::*;
   import core_ctrl_pkg::*;

   logic [15:0] imm16;

   assign imm16 = instr.i.imm16;

   always_comb
   begin
      // idle control word, fall through to pc+4
      ctrl = '0;
      ctrl.alu_op = ALU_ADD;
      ctrl.br_cond = BR_NONE;
      ctrl.pc_sel = PC_SEQ;
      // sign extension unless the opcode says otherwise
      imm_ext = {{16{imm16[15]}}, imm16};
      // opcode lies at the same bits in every view
      case (instr.j.op)
         OP_SPECIAL:
         begin
            ctrl.reg_we = 1'b1;
            ctrl.dst_rd = 1'b1;
            case (instr.r.funct)
               FN_ADD, FN_ADDU: ctrl.alu_op = ALU_ADD;
               FN_SUB, FN_SUBU: ctrl.alu_op = ALU_SUB;
               FN_AND: ctrl.alu_op = ALU_AND;
               FN_OR: ctrl.alu_op = ALU_OR;
               FN_XOR: ctrl.alu_op = ALU_XOR;
               FN_NOR: ctrl.alu_op = ALU_NOR;
               FN_SLT: ctrl.alu_op = ALU_SLT;
               FN_SLL: ctrl.alu_op = ALU_SLL;
               FN_SRL: ctrl.alu_op = ALU_SRL;
               FN_SRA: ctrl.alu_op = ALU_SRA;
               FN_JR:
               begin
                  ctrl.reg_we = 1'b0;
                  ctrl.pc_sel = PC_REG;
               end
               FN_SYSCALL:
               begin
                  ctrl.reg_we = 1'b0;
                  ctrl.halt_req = 1'b1;
               end
               default:
               begin
                  // reserved funct
                  ctrl.reg_we = 1'b0;
                  ctrl.halt_req = 1'b1;
               end
            endcase
         end
         OP_REGIMM:
         begin
            ctrl.pc_sel = PC_BRANCH;
            case (instr.i.rt)
               RI_BLTZ: ctrl.br_cond = BR_LTZ;
               RI_BGEZ: ctrl.br_cond = BR_GEZ;
               default: ctrl.halt_req = 1'b1;
            endcase
         end
         OP_J: ctrl.pc_sel = PC_JUMP;
         OP_JAL:
         begin
            // r31 gets pc+4
            ctrl.pc_sel = PC_JUMP;
            ctrl.reg_we = 1'b1;
            ctrl.link = 1'b1;
         end
         OP_BEQ, OP_BNE, OP_BLEZ, OP_BGTZ:
         begin
            ctrl.pc_sel = PC_BRANCH;
            case (instr.j.op)
               OP_BEQ: ctrl.br_cond = BR_EQ;
               OP_BNE: ctrl.br_cond = BR_NE;
               OP_BLEZ: ctrl.br_cond = BR_LEZ;
               default: ctrl.br_cond = BR_GTZ;
            endcase
         end
         OP_ADDI, OP_ADDIU, OP_SLTI, OP_ANDI, OP_ORI, OP_XORI, OP_LUI:
         begin
            ctrl.reg_we = 1'b1;
            ctrl.use_imm = 1'b1;
            case (instr.j.op)
               OP_SLTI: ctrl.alu_op = ALU_SLT;
               OP_ANDI: ctrl.alu_op = ALU_AND;
               OP_ORI: ctrl.alu_op = ALU_OR;
               OP_XORI: ctrl.alu_op = ALU_XOR;
               OP_LUI: ctrl.alu_op = ALU_PASS_B;
               default: ctrl.alu_op = ALU_ADD;
            endcase
            // logic ops zero extend, lui fills the upper half
            if (instr.j.op == OP_ANDI || instr.j.op == OP_ORI || instr.j.op == OP_XORI)
               imm_ext = {16'h0, imm16};
            else if (instr.j.op == OP_LUI)
               imm_ext = {imm16, 16'h0};
         end
         OP_LW:
         begin
            ctrl.reg_we = 1'b1;
            ctrl.use_imm = 1'b1;
            ctrl.mem_to_reg = 1'b1;
         end
         OP_SW:
         begin
            ctrl.use_imm = 1'b1;
            ctrl.mem_we = 1'b1;
         end
         default: ctrl.halt_req = 1'b1;
      endcase
   end

endmodule

// ==== logic/alu.sv ====
// alu: add, sub, logic, slt, constant shifts and branch compare
`timescale 1ns/1ps
`include "core_settings.svh"

module alu (
   input  logic [`CORE_XLEN-1:0]    op_a,
   input  logic [`CORE_XLEN-1:0]    op_b,
   input  logic [4:0]               shamt,
   input  core_ctrl_pkg::alu_op_e   alu_op,
   input  core_ctrl_pkg::br_cond_e  br_cond,
   output logic [`CORE_XLEN-1:0]    result,
   output logic                     branch_taken
);
   import core_ctrl_pkg::*;

   logic a_zero;
   logic a_neg;

   assign a_zero = (op_a == '0);
   assign a_neg = op_a[`CORE_XLEN-1];

   always_comb
   begin
      case (alu_op)
         // add and sub wrap, no overflow trap
         ALU_ADD: result = op_a + op_b;
         ALU_SUB: result = op_a - op_b;
         ALU_AND: result = op_a & op_b;
         ALU_OR: result = op_a | op_b;
         ALU_XOR: result = op_a ^ op_b;
         ALU_NOR: result = ~(op_a | op_b);
         ALU_SLT: result = {{(`CORE_XLEN-1){1'b0}}, $signed(op_a) < $signed(op_b)};
         // shifts act on rt
         ALU_SLL: result = op_b << shamt;
         ALU_SRL: result = op_b >> shamt;
         ALU_SRA: result = $signed(op_b) >>> shamt;
         ALU_PASS_B: result = op_b;
         default: result = '0;
      endcase
   end

   // op_a is rs, op_b is rt
   always_comb
   begin
      case (br_cond)
         BR_EQ: branch_taken = (op_a == op_b);
         BR_NE: branch_taken = (op_a != op_b);
         BR_LTZ: branch_taken = a_neg;
         BR_GEZ: branch_taken = ~a_neg;
         BR_LEZ: branch_taken = a_neg | a_zero;
         BR_GTZ: branch_taken = ~a_neg & ~a_zero;
         default: branch_taken = 1'b0;
      endcase
   end

endmodule

// ==== logic/reg_file.sv ====
// register file: two async read ports, one write port, r0 fixed at zero
`timescale 1ns/1ps
`include "core_settings.svh"

module reg_file (
   input  logic                 clk,
   input  logic                 rst_b,
   input  logic [4:0]           rs_addr,
   input  logic [4:0]           rt_addr,
   input  logic [4:0]           wr_addr,
   input  logic                 wr_en,
   input  logic [`CORE_XLEN-1:0] wr_data,
   output logic [`CORE_XLEN-1:0] rs_data,
   output logic [`CORE_XLEN-1:0] rt_data
);

   // no storage behind r0
   logic [`CORE_XLEN-1:0] regs [1:`CORE_NREGS-1];

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         for (int i = 1; i < `CORE_NREGS; i++)
            regs[i] <= '0;
      end
      else if (wr_en && wr_addr != 5'd0)
         regs[wr_addr] <= wr_data;
   end

   // reads see the old value until the edge
   assign rs_data = (rs_addr == 5'd0) ? '0 : regs[rs_addr];
   assign rt_data = (rt_addr == 5'd0) ? '0 : regs[rt_addr];

endmodule

// ==== logic/fetch_unit.sv ====
// fetch unit: pc register, next-pc mux, branch and jump targets, halt flag
`timescale 1ns/1ps
`include "core_settings.svh"

module fetch_unit (
   input  logic                      clk,
   input  logic                      rst_b,
   input  core_ctrl_pkg::ctrl_word_t ctrl,
   input  logic                      branch_taken,
   input  logic [`CORE_XLEN-1:0]     imm_ext,
   input  logic [`CORE_XLEN-1:0]     rs_data,
   input  logic [25:0]               target,
   output logic [`CORE_XLEN-1:0]     pc,
   output logic [`CORE_XLEN-1:0]     pc_plus4,
   output logic                      halted
);
   import core_ctrl_pkg::*;

   logic [`CORE_XLEN-1:0] br_target;
   logic [`CORE_XLEN-1:0] jmp_target;
   logic [`CORE_XLEN-1:0] next_pc;

   assign pc_plus4 = pc + 32'd4;
   // word offset, relative to the following instruction
   assign br_target = pc_plus4 + {imm_ext[29:0], 2'b00};
   // region bits come from the current pc
   assign jmp_target = {pc[31:28], target, 2'b00};

   always_comb
   begin
      case (ctrl.pc_sel)
         PC_BRANCH: next_pc = branch_taken ? br_target : pc_plus4;
         PC_JUMP: next_pc = jmp_target;
         PC_REG: next_pc = rs_data;
         default: next_pc = pc_plus4;
      endcase
   end

   always_ff @(posedge clk or negedge rst_b)
   begin
      if (!rst_b)
      begin
         pc <= `CORE_TEXT_START;
         halted <= 1'b0;
      end
      else
      begin
         // sticky until reset
         if (ctrl.halt_req)
            halted <= 1'b1;
         // pc parks on the halting instruction
         if (!halted && !ctrl.halt_req)
            pc <= next_pc;
      end
   end

endmodule

// ==== logic/mips_core.sv ====
// single-cycle core top: decoder, register file, alu, fetch unit and memory ports
`timescale 1ns/1ps

module mips_core (
   input  logic                     clk,
   input  logic                     rst_b,
   output logic [29:0]              inst_addr,
   input  logic [31:0]              inst,
   output core_ctrl_pkg::dmem_req_t dmem_req,
   input  logic [31:0]              dmem_rdata,
   output logic                     halted
);
   import mips_isa_pkg::*;
   import core_ctrl_pkg::*;

   mips_instr_u instr;
   ctrl_word_t  ctrl;
   logic [31:0] imm_ext;
   logic [31:0] rs_data;
   logic [31:0] rt_data;
   logic [31:0] alu_b;
   logic [31:0] alu_result;
   logic [31:0] wr_data;
   logic [31:0] pc;
   logic [31:0] pc_plus4;
   logic [4:0]  wr_addr;
   logic        wr_en;
   logic        branch_taken;
   logic        retire;

   assign instr = inst;
   assign inst_addr = pc[31:2];

   // side effects only for a live, non-halting instruction
   assign retire = ~ctrl.halt_req & ~halted;

   instr_decoder decoder_i (
      .instr   (instr),
      .ctrl    (ctrl),
      .imm_ext (imm_ext)
   );

   // destination: r31 for jal, rd for r-type, rt otherwise
   assign wr_addr = ctrl.link ? 5'd31 : (ctrl.dst_rd ? instr.r.rd : instr.i.rt);
   assign wr_data = ctrl.link ? pc_plus4 : (ctrl.mem_to_reg ? dmem_rdata : alu_result);
   assign wr_en = ctrl.reg_we & retire;

   reg_file reg_file_i (
      .clk     (clk),
      .rst_b   (rst_b),
      .rs_addr (instr.i.rs),
      .rt_addr (instr.i.rt),
      .wr_addr (wr_addr),
      .wr_en   (wr_en),
      .wr_data (wr_data),
      .rs_data (rs_data),
      .rt_data (rt_data)
   );

   assign alu_b = ctrl.use_imm ? imm_ext : rt_data;

   alu alu_i (
      .op_a         (rs_data),
      .op_b         (alu_b),
      .shamt        (instr.r.shamt),
      .alu_op       (ctrl.alu_op),
      .br_cond      (ctrl.br_cond),
      .result       (alu_result),
      .branch_taken (branch_taken)
   );

   // effective address from the alu, store data straight from rt
   assign dmem_req.addr = alu_result[31:2];
   assign dmem_req.wdata = rt_data;
   assign dmem_req.we = ctrl.mem_we & retire;

   fetch_unit fetch_i (
      .clk          (clk),
      .rst_b        (rst_b),
      .ctrl         (ctrl),
      .branch_taken (branch_taken),
      .imm_ext      (imm_ext),
      .rs_data      (rs_data),
      .target       (instr.j.target26),
      .pc           (pc),
      .pc_plus4     (pc_plus4),
      .halted       (halted)
   );

endmodule

// ==== test/mips_core_asserts.sv ====
// bound assertions on mips_core: sticky halt, no store and fixed fetch address while halted
`timescale 1ns/1ps

module mips_core_asserts (
   input logic                     clk,
   input logic                     rst_b,
   input logic                     halted,
   input logic [29:0]              inst_addr,
   input core_ctrl_pkg::dmem_req_t dmem_req
);

   // halt only clears through reset
   halt_sticky: assert property (@(posedge clk) disable iff (!rst_b) halted |=> halted)
      else $error("halted fell without reset");

   no_store_halted: assert property (@(posedge clk) disable iff (!rst_b)
                                     !(halted && dmem_req.we))
      else $error("store enable high while halted");

   // pc parked on the halting instruction
   pc_parked: assert property (@(posedge clk) disable iff (!rst_b)
                               halted |=> $stable(inst_addr))
      else $error("fetch address moved while halted");

endmodule

bind mips_core mips_core_asserts asserts_i (
   .clk       (clk),
   .rst_b     (rst_b),
   .halted    (halted),
   .inst_addr (inst_addr),
   .dmem_req  (dmem_req)
);

// ==== test/mips_core_tb.sv ====
// testbench for mips_core: clock, reset, trace reader, memory models, store and halt checks
`timescale 1ns/1ps
`include "core_settings.svh"

module mips_core_tb;
   import core_ctrl_pkg::*;

   localparam int RESET_CYCLES = 16;
   localparam int MEM_WORDS = 256;
   localparam logic [29:0] TEXT_WORD = 30'(`CORE_TEXT_START >> 2);

   logic        clk;
   logic        rst_b;
   logic [29:0] inst_addr;
   logic [31:0] inst;
   dmem_req_t   dmem_req;
   logic [31:0] dmem_rdata;
   logic        halted;

   logic [31:0] imem [0:MEM_WORDS-1];
   logic [31:0] dmem [0:MEM_WORDS-1];

   // trace contents, one entry per test, words and stores kept flat
   string       test_name [$];
   int          prog_first [$];
   int          prog_count [$];
   int          store_first [$];
   int          store_count [$];
   logic [29:0] halt_word [$];
   logic [31:0] prog_word [$];
   logic [29:0] store_addr [$];
   logic [31:0] store_data [$];

   string cur_test;
   int    store_base;
   int    store_next;
   int    store_end;
   int    errors;
   int    unmatched;
   int    cycles;
   int    cycle_limit;

   mips_core mips_core_i (
      .clk        (clk),
      .rst_b      (rst_b),
      .inst_addr  (inst_addr),
      .inst       (inst),
      .dmem_req   (dmem_req),
      .dmem_rdata (dmem_rdata),
      .halted     (halted)
   );

   initial
   begin
      clk = 1'b0;
      forever #10 clk = ~clk;
   end

   // reserved opcode 0x3f, rest of the word from the full word address
   function automatic logic [31:0] reserved_fill(input logic [29:0] addr);
      return {6'h3f, addr[25:0] ^ {22'h0, addr[29:26]}};
   endfunction

   function automatic logic [31:0] fetch_word(input logic [29:0] addr);
      logic [29:0] idx;
      idx = addr - TEXT_WORD;
      if (idx < MEM_WORDS)
         return imem[idx];
      return reserved_fill(addr);
   endfunction

   task automatic read_trace();
      int          fd;
      int          n;
      int          last;
      string       tok;
      string       line;
      logic [29:0] a;
      logic [31:0] d;
      fd = $fopen("test/core_trace.txt", "r");
      if (fd == 0)
      begin
         $display("could not open the trace file test/core_trace.txt");
         errors++;
         return;
      end
      while ($fscanf(fd, "%s", tok) == 1)
      begin
         last = test_name.size() - 1;
         if (tok == "#")
            n = $fgets(line, fd);
         else if (tok == "test")
         begin
            n = $fscanf(fd, "%s", tok);
            test_name.push_back(tok);
            prog_first.push_back(prog_word.size());
            prog_count.push_back(0);
            store_first.push_back(store_addr.size());
            store_count.push_back(0);
            halt_word.push_back('0);
         end
         else if (tok == "st")
         begin
            n = $fscanf(fd, "%h %h", a, d);
            store_addr.push_back(a);
            store_data.push_back(d);
            store_count[last]++;
         end
         else if (tok == "halt")
         begin
            n = $fscanf(fd, "%h", a);
            halt_word[last] = a;
         end
         else
         begin
            // anything else is a program word in hex
            n = $sscanf(tok, "%h", d);
            prog_word.push_back(d);
            prog_count[last]++;
         end
      end
      $fclose(fd);
   endtask

   task automatic check_store();
      dmem[dmem_req.addr[7:0]] = dmem_req.wdata;
      if (halted)
      begin
         errors++;
         $display("%s: a store was issued while the core was halted", cur_test);
      end
      else if (store_next >= store_end)
      begin
         unmatched++;
         $display("%s: unexpected store of %h to word %h", cur_test, dmem_req.wdata,
                  dmem_req.addr);
      end
      else
      begin
         if (dmem_req.addr != store_addr[store_next] ||
             dmem_req.wdata != store_data[store_next])
         begin
            errors++;
            $display("** Error %s: store %0d expected %h <- %h, actual %h <- %h", cur_test,
                     store_next - store_base, store_addr[store_next],
                     store_data[store_next], dmem_req.addr, dmem_req.wdata);
         end
         store_next++;
      end
   endtask

   task automatic end_run();
      $display("errors: %0d, unmatched stores: %0d", errors, unmatched);
      if (errors == 0 && unmatched == 0)
         $display("Regression passed");
      else
         $display("Regression failed");
      $finish;
   endtask

   task automatic run_test(input int t);
      cur_test = test_name[t];
      for (int i = 0; i < MEM_WORDS; i++)
      begin
         imem[i] = reserved_fill(TEXT_WORD + 30'(i));
         dmem[i] = '0;
      end
      for (int k = 0; k < prog_count[t]; k++)
         imem[k] = prog_word[prog_first[t] + k];
      store_base = store_first[t];
      store_next = store_first[t];
      store_end = store_first[t] + store_count[t];
      @(posedge clk);
      #2 rst_b = 1'b0;
      repeat (RESET_CYCLES) @(posedge clk);
      #2 rst_b = 1'b1;
      // run until the core halts, the cycle counter guards against a hang
      do
      begin
         @(posedge clk);
         #5;
      end
      while (!halted);
      if (inst_addr != halt_word[t])
      begin
         errors++;
         $display("** Error %s: halt word address expected %h, actual %h", cur_test,
                  halt_word[t], inst_addr);
      end
      // a few idle cycles, no store may show up here
      repeat (4) @(posedge clk);
      if (store_next != store_end)
      begin
         unmatched += store_end - store_next;
         $display("%s: %0d expected stores were never seen", cur_test, store_end - store_next);
      end
   endtask

   // memory side of the core, driven shortly after each rising edge
   always @(posedge clk)
   begin
      #2 inst = fetch_word(inst_addr);
      #1 dmem_rdata = dmem[dmem_req.addr[7:0]];
      #1 if (rst_b && dmem_req.we)
         check_store();
   end

   // edge count for the hang guard
   always @(posedge clk)
      cycles++;

   initial
   begin
      wait (cycle_limit > 0 && cycles > cycle_limit);
      errors++;
      $display("timeout: the run did not finish within %0d cycles", cycle_limit);
      end_run();
   end

   initial
   begin
      inst = '0;
      dmem_rdata = '0;
      rst_b = 1'b0;
      errors = 0;
      unmatched = 0;
      cycles = 0;
      read_trace();
      // every word at most four cycles, plus reset per test
      cycle_limit = prog_word.size() * 4 + RESET_CYCLES * test_name.size();
      for (int t = 0; t < test_name.size(); t++)
         run_test(t);
      end_run();
   end

endmodule

// ==== test/core_trace.txt ====
# test NAME starts a test, bare hex tokens are program words from 0x00400000
# st WORDADDR DATA is the next expected store, halt WORDADDR is the halting fetch address
test core
3C011234 34215678 3C02F000 344200FF 00221820 AC030000 00222022 AC040004
00222824 AC050008 00223025 AC06000C 00223826 AC070010 00224027 AC080014
0041482A AC090018 00025900 AC0B001C 00026202 AC0C0020 00026A03 AC0D0024
200EFFFD AC0E0028 31CF8001 AC0F002C 39D000FF AC100030 29D1FFFE AC110034
8C130004 AC130038 AC00003C 8C140038 AC140040 10210001 AC010100 10220001
AC010044 14220001 AC010100 14210001 AC020048 04400001 AC010100 04200001
AC03004C 04210001 AC010100 04410001 AC040050 18000001 AC010100 18200001
AC050054 1C200001 AC010100 1C400001 AC060058 0810003F AC010100 0C100042
AC1F005C 08100044 03E00008 AC010100 0000000C AC010100
st 00 02345777 st 01 22345579 st 02 10000078 st 03 F23456FF
st 04 E2345687 st 05 0DCBA900 st 06 00000001 st 07 00000FF0
st 08 00F00000 st 09 FFF00000 st 0A FFFFFFFD st 0B 00008001
st 0C FFFFFF02 st 0D 00000001 st 0E 22345579 st 0F 00000000
st 10 22345579 st 11 12345678 st 12 F00000FF st 13 02345777
st 14 22345579 st 15 10000078 st 16 F23456FF st 17 00400100
halt 100044
test reserved
20010005 AC010000 FC000000 AC010004
st 00 00000005
halt 100002

// ==== files.f ====
+incdir+logic
logic/mips_isa_pkg.sv
logic/core_ctrl_pkg.sv
logic/instr_decoder.sv
logic/alu.sv
logic/reg_file.sv
logic/fetch_unit.sv
logic/mips_core.sv
test/mips_core_asserts.sv
test/mips_core_tb.sv

// ==== Makefile ====
LOG = sim.log

.PHONY: sim clean

sim:
	verilator --binary --timing --assert --top-module mips_core_tb -f files.f -o vsim
	./obj_dir/vsim | tee $(LOG)
	grep -q "Regression passed" $(LOG)

clean:
	rm -rf obj_dir $(LOG)
